//--- hw/walkie_audio_config.svh
`ifndef WALKIE_AUDIO_CONFIG_SVH
`define WALKIE_AUDIO_CONFIG_SVH

// Audio sample width in bits
`define SAMPLE_W 8

// hwclk cycles per half period of i2sclk and spiclk
`define I2S_DIV 4
`define SPI_DIV 2

// Echo ring depth in samples, one SRAM word per slot
`define DELAY_SAMPLES 4
`define DELAY_BASE 32'h3000_0000

// Wishbone bus widths
`define WB_ADDR_W 32
`define WB_DATA_W 32

`endif

//--- hw/walkie_audio_pkg.sv
package walkie_audio_pkg;

  typedef enum logic [1:0] {
    CLEAN  = 2'd0,  // Straight through
    CRUSH  = 2'd1,  // Low nibble dropped
    ECHO   = 2'd2,  // Average with delayed sample
    INVERT = 2'd3   // Mirror around full scale
  } effect_e;

  typedef enum logic [1:0] {
    EXEC_IDLE,      // Waiting for a new sample
    EXEC_WAIT_MEM,  // Delay line busy
    EXEC_EMIT       // Byte strobe cycle
  } exec_state_e;

  typedef enum logic [1:0] {
    WB_IDLE,
    WB_READ,   // Fetch of the old sample
    WB_WRITE   // Store of the new one
  } wb_state_e;

  typedef enum logic [1:0] {
    SPI_IDLE,
    SPI_SHIFT,  // cs low, clocking bits
    SPI_DONE    // Release cs
  } spi_state_e;

endpackage

//--- hw/audio_bus_if.sv
`timescale 1ns/1ps
`include "walkie_audio_config.svh"

interface audio_bus_if ();

  logic [`SAMPLE_W-1:0]       sample;        // Last mic word
  logic                       sample_valid;  // One-cycle pulse per frame
  walkie_audio_pkg::effect_e  effect;        // Selected effect
  logic                       transmit;      // PTT held and not muted
  logic [1:0]                 vol_shift;     // Right shift amount

  modport capture (
    output sample, sample_valid
  );

  modport decode (
    output effect, transmit, vol_shift
  );

  modport execute (
    input sample, sample_valid, effect, transmit, vol_shift
  );

endinterface

//--- hw/delay_mem_if.sv
`timescale 1ns/1ps
`include "walkie_audio_config.svh"

interface delay_mem_if ();

  logic                  req;         // Pulse, one store/fetch pair
  logic [`SAMPLE_W-1:0]  store_data;  // New sample to write
  logic [`SAMPLE_W-1:0]  fetch_data;  // Sample from DELAY_SAMPLES ago
  logic                  done;        // Pulse, pair finished

  modport requester (
    output req, store_data,
    input  fetch_data, done
  );

  modport memory (
    input  req, store_data,
    output fetch_data, done
  );

endinterface

//--- hw/i2s_capture.sv
`timescale 1ns/1ps
`include "walkie_audio_config.svh"

module i2s_capture (
  input  logic         hwclk,
  input  logic         arst_n,
  input  logic         adc_serial_in,  // Serial data from mic
  output logic         i2sclk,         // Bit clock to mic
  output logic         ws_adc,         // Word select to mic
  audio_bus_if.capture bus
);

  localparam int DIV_W = (`I2S_DIV > 1) ? $clog2(`I2S_DIV) : 1;
  localparam int BIT_W = $clog2(2 * `SAMPLE_W);  // Slots per frame, both halves

  logic [DIV_W-1:0]     div_cnt;   // Half period counter
  logic [BIT_W-1:0]     bit_cnt;   // Slot within frame
  logic [`SAMPLE_W-1:0] shreg;     // Collected bits, MSB first
  logic                 i2s_tick;  // i2sclk about to toggle
  logic                 i2s_rise;
  logic                 i2s_fall;
  logic                 last_bit;  // Final slot of the low half

  assign i2s_tick = (div_cnt == DIV_W'(`I2S_DIV - 1));
  assign i2s_rise = i2s_tick && !i2sclk;
  assign i2s_fall = i2s_tick && i2sclk;
  assign last_bit = (bit_cnt[BIT_W-2:0] == (BIT_W-1)'(`SAMPLE_W - 1));
  assign ws_adc   = bit_cnt[BIT_W-1];  // Low half carries the word
  assign bus.sample = shreg;           // Held until next frame's first bit

  always_ff @(posedge hwclk or negedge arst_n) begin
    if (!arst_n) begin
      div_cnt          <= '0;
      i2sclk           <= 1'b0;
      bit_cnt          <= '0;
      bus.sample_valid <= 1'b0;
    end else begin
      // Valid in the cycle after the 8th rising edge
      bus.sample_valid <= i2s_rise && !ws_adc && last_bit;
      if (i2s_tick) begin
        div_cnt <= '0;
        i2sclk  <= !i2sclk;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
      if (i2s_fall) begin
        bit_cnt <= bit_cnt + 1'b1;  // ws moves on falling edge
      end
    end
  end

  always_ff @(posedge hwclk) begin
    if (i2s_rise && !ws_adc) begin
      shreg <= {shreg[`SAMPLE_W-2:0], adc_serial_in};  // Sample on rising edge
    end
  end

endmodule

//--- hw/control_decode.sv
`timescale 1ns/1ps

module control_decode (
  input  logic       hwclk,
  input  logic       arst_n,
  input  logic [3:0] pbs,  // 0 next effect, 1 mute, 2 PTT, 3 clean
  input  logic [1:0] vol,  // Volume shift select
  audio_bus_if.decode bus
);

  logic [5:0]                sync_a;    // First stage, {vol, pbs}
  logic [5:0]                sync_b;    // Second stage
  logic [3:0]                btn_prev;  // For edge detect
  logic [3:0]                press;     // Rising edges
  logic                      mute;
  logic                      mute_next;
  walkie_audio_pkg::effect_e effect;

  assign press         = sync_b[3:0] & ~btn_prev;
  assign mute_next     = mute ^ press[1];  // Toggle per press
  assign bus.effect    = effect;

  always_ff @(posedge hwclk or negedge arst_n) begin
    if (!arst_n) begin
      sync_a        <= '0;
      sync_b        <= '0;
      btn_prev      <= '0;
      mute          <= 1'b0;
      effect        <= walkie_audio_pkg::CLEAN;
      bus.transmit  <= 1'b0;
      bus.vol_shift <= '0;
    end else begin
      sync_a   <= {vol, pbs};
      sync_b   <= sync_a;
      btn_prev <= sync_b[3:0];
      mute     <= mute_next;
      // Uses next mute so a mute press lands on the same cycle
      bus.transmit  <= sync_b[2] && !mute_next;
      bus.vol_shift <= sync_b[5:4];
      if (press[3]) begin
        effect <= walkie_audio_pkg::CLEAN;  // Reset button wins
      end else if (press[0]) begin
        case (effect)
          walkie_audio_pkg::CLEAN:  effect <= walkie_audio_pkg::CRUSH;
          walkie_audio_pkg::CRUSH:  effect <= walkie_audio_pkg::ECHO;
          walkie_audio_pkg::ECHO:   effect <= walkie_audio_pkg::INVERT;
          default:                  effect <= walkie_audio_pkg::CLEAN;
        endcase
      end
    end
  end

endmodule

//--- hw/effect_execute.sv
`timescale 1ns/1ps
`include "walkie_audio_config.svh"

module effect_execute (
  input  logic                 hwclk,
  input  logic                 arst_n,
  audio_bus_if.execute         bus,
  delay_mem_if.requester       mem,
  output logic [`SAMPLE_W-1:0] tx_byte,   // Byte for the radio
  output logic                 tx_strobe  // Pulse, byte ready
);

  walkie_audio_pkg::exec_state_e state;
  walkie_audio_pkg::effect_e     effect_q;    // Settings frozen per sample
  logic [`SAMPLE_W-1:0]          sample_q;
  logic                          transmit_q;
  logic [1:0]                    vol_q;
  logic [`SAMPLE_W:0]            echo_sum;    // One extra bit for carry
  logic [`SAMPLE_W-1:0]          fx;          // Effect output before volume
  logic                          take;        // Accept a new sample

  assign take           = (state == walkie_audio_pkg::EXEC_IDLE) && bus.sample_valid;
  assign mem.store_data = sample_q;
  assign echo_sum       = {1'b0, sample_q} + {1'b0, mem.fetch_data};

  always_comb begin
    case (effect_q)
      walkie_audio_pkg::CLEAN:  fx = sample_q;
      walkie_audio_pkg::CRUSH:  fx = {sample_q[`SAMPLE_W-1:4], 4'b0000};
      walkie_audio_pkg::ECHO:   fx = echo_sum[`SAMPLE_W:1];  // Floor of average
      walkie_audio_pkg::INVERT: fx = ~sample_q;              // Same as full scale minus x
      default:                  fx = sample_q;
    endcase
  end

  always_ff @(posedge hwclk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= walkie_audio_pkg::EXEC_IDLE;
      mem.req   <= 1'b0;
      tx_strobe <= 1'b0;
    end else begin
      mem.req   <= 1'b0;
      tx_strobe <= 1'b0;
      case (state)
        walkie_audio_pkg::EXEC_IDLE: begin
          if (bus.sample_valid) begin
            mem.req <= 1'b1;  // One cycle after sample_valid
            state   <= walkie_audio_pkg::EXEC_WAIT_MEM;
          end
        end
        walkie_audio_pkg::EXEC_WAIT_MEM: begin
          if (mem.done) begin
            tx_strobe <= transmit_q;  // Store always, send only on PTT
            state     <= walkie_audio_pkg::EXEC_EMIT;
          end
        end
        walkie_audio_pkg::EXEC_EMIT: begin
          state <= walkie_audio_pkg::EXEC_IDLE;  // Strobe is high this cycle
        end
        default: state <= walkie_audio_pkg::EXEC_IDLE;
      endcase
    end
  end

  always_ff @(posedge hwclk) begin
    if (take) begin
      sample_q   <= bus.sample;
      effect_q   <= bus.effect;
      transmit_q <= bus.transmit;
      vol_q      <= bus.vol_shift;
    end
    if ((state == walkie_audio_pkg::EXEC_WAIT_MEM) && mem.done) begin
      tx_byte <= fx >> vol_q;  // fetch_data valid with done
    end
  end

endmodule

//--- hw/delay_line_wb.sv
`timescale 1ns/1ps
`include "walkie_audio_config.svh"

module delay_line_wb (
  input  logic                  hwclk,
  input  logic                  arst_n,
  delay_mem_if.memory           mem,
  input  logic [`WB_DATA_W-1:0] wdati,  // Read data from SRAM
  input  logic                  wack,
  output logic [`WB_ADDR_W-1:0] wadr,
  output logic [3:0]            wsel,
  output logic                  wwe,
  output logic                  wstb,
  output logic                  wcyc,
  output logic [`WB_DATA_W-1:0] wdato
);

  localparam int PTR_W = (`DELAY_SAMPLES > 1) ? $clog2(`DELAY_SAMPLES) : 1;

  walkie_audio_pkg::wb_state_e state;
  logic [PTR_W-1:0]            ptr;       // Oldest slot, also next to write
  logic [PTR_W-1:0]            ptr_next;

  assign ptr_next = (ptr == PTR_W'(`DELAY_SAMPLES - 1)) ? '0 : ptr + 1'b1;
  assign wadr     = `DELAY_BASE + `WB_ADDR_W'({ptr, 2'b00});  // Word per slot
  assign wsel     = 4'b0001;                                  // Low byte lane only
  assign wdato    = `WB_DATA_W'(mem.store_data);

  always_ff @(posedge hwclk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= walkie_audio_pkg::WB_IDLE;
      ptr      <= '0;
      wcyc     <= 1'b0;
      wstb     <= 1'b0;
      wwe      <= 1'b0;
      mem.done <= 1'b0;
    end else begin
      mem.done <= 1'b0;
      case (state)
        walkie_audio_pkg::WB_IDLE: begin
          if (mem.req) begin
            wcyc  <= 1'b1;  // Read cycle starts
            wstb  <= 1'b1;
            wwe   <= 1'b0;
            state <= walkie_audio_pkg::WB_READ;
          end
        end
        walkie_audio_pkg::WB_READ: begin
          if (wack) begin
            wcyc  <= 1'b0;  // One idle cycle between accesses
            wstb  <= 1'b0;
            state <= walkie_audio_pkg::WB_WRITE;
          end
        end
        walkie_audio_pkg::WB_WRITE: begin
          if (!wcyc) begin
            wcyc <= 1'b1;  // Write to the same slot
            wstb <= 1'b1;
            wwe  <= 1'b1;
          end else if (wack) begin
            wcyc     <= 1'b0;
            wstb     <= 1'b0;
            wwe      <= 1'b0;
            ptr      <= ptr_next;
            mem.done <= 1'b1;
            state    <= walkie_audio_pkg::WB_IDLE;
          end
        end
        default: state <= walkie_audio_pkg::WB_IDLE;
      endcase
    end
  end

  // Old sample, held for execute after done
  always_ff @(posedge hwclk) begin
    if ((state == walkie_audio_pkg::WB_READ) && wack) begin
      mem.fetch_data <= wdati[`SAMPLE_W-1:0];
    end
  end

endmodule

//--- hw/esp_spi_result.sv
`timescale 1ns/1ps
`include "walkie_audio_config.svh"

module esp_spi_result (
  input  logic                 hwclk,
  input  logic                 arst_n,
  input  logic [`SAMPLE_W-1:0] tx_byte,
  input  logic                 tx_strobe,  // Ignored while busy
  output logic                 cs,         // Active low to ESP32
  output logic                 spiclk,
  output logic                 mosi
);

  localparam int DIV_W = (`SPI_DIV > 1) ? $clog2(`SPI_DIV) : 1;
  localparam int BIT_W = $clog2(`SAMPLE_W);

  walkie_audio_pkg::spi_state_e state;
  logic [DIV_W-1:0]             div_cnt;   // Half period counter
  logic [BIT_W-1:0]             bit_cnt;   // Bits sent so far
  logic [`SAMPLE_W-1:0]         shreg;     // MSB drives mosi
  logic                         spi_tick;  // spiclk about to toggle

  assign spi_tick = (div_cnt == DIV_W'(`SPI_DIV - 1));
  assign mosi     = shreg[`SAMPLE_W-1];

  always_ff @(posedge hwclk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= walkie_audio_pkg::SPI_IDLE;
      div_cnt <= '0;
      bit_cnt <= '0;
      shreg   <= '0;
      cs      <= 1'b1;
      spiclk  <= 1'b0;
    end else begin
      case (state)
        walkie_audio_pkg::SPI_IDLE: begin
          if (tx_strobe) begin
            shreg   <= tx_byte;  // MSB out before first rising edge
            cs      <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
            state   <= walkie_audio_pkg::SPI_SHIFT;
          end
        end
        walkie_audio_pkg::SPI_SHIFT: begin
          div_cnt <= spi_tick ? '0 : div_cnt + 1'b1;
          if (spi_tick) begin
            spiclk <= !spiclk;
            if (spiclk) begin  // Falling edge, next bit out
              shreg   <= shreg << 1;
              bit_cnt <= bit_cnt + 1'b1;
              if (bit_cnt == BIT_W'(`SAMPLE_W - 1)) begin
                state <= walkie_audio_pkg::SPI_DONE;
              end
            end
          end
        end
        walkie_audio_pkg::SPI_DONE: begin
          cs    <= 1'b1;
          state <= walkie_audio_pkg::SPI_IDLE;
        end
        default: state <= walkie_audio_pkg::SPI_IDLE;
      endcase
    end
  end

endmodule

//--- hw/walkie_audio_top.sv
`timescale 1ns/1ps
`include "walkie_audio_config.svh"

module walkie_audio_top (
  input  logic                  hwclk,
  input  logic                  arst_n,
  input  logic                  adc_serial_in,  // From mic
  input  logic [3:0]            pbs,            // Push buttons
  input  logic [1:0]            vol,            // Volume switches
  input  logic [`WB_DATA_W-1:0] wdati,
  input  logic                  wack,
  output logic                  i2sclk,         // To mic
  output logic                  ws_adc,         // To mic
  output logic                  cs,             // To ESP32
  output logic                  spiclk,         // To ESP32
  output logic                  mosi,           // To ESP32
  output logic [`WB_ADDR_W-1:0] wadr,
  output logic [3:0]            wsel,
  output logic                  wwe,
  output logic                  wstb,
  output logic                  wcyc,
  output logic [`WB_DATA_W-1:0] wdato
);

  logic [`SAMPLE_W-1:0] tx_byte;    // Execute to SPI
  logic                 tx_strobe;

  audio_bus_if abus ();
  delay_mem_if dmem ();

  i2s_capture u_capture (
    .hwclk(hwclk), .arst_n(arst_n), .adc_serial_in(adc_serial_in),
    .i2sclk(i2sclk), .ws_adc(ws_adc), .bus(abus)
  );

  control_decode u_decode (
    .hwclk(hwclk), .arst_n(arst_n), .pbs(pbs), .vol(vol), .bus(abus)
  );

  effect_execute u_execute (
    .hwclk(hwclk), .arst_n(arst_n), .bus(abus), .mem(dmem),
    .tx_byte(tx_byte), .tx_strobe(tx_strobe)
  );

  delay_line_wb u_delay (
    .hwclk(hwclk), .arst_n(arst_n), .mem(dmem),
    .wdati(wdati), .wack(wack), .wadr(wadr), .wsel(wsel),
    .wwe(wwe), .wstb(wstb), .wcyc(wcyc), .wdato(wdato)
  );

  esp_spi_result u_result (
    .hwclk(hwclk), .arst_n(arst_n), .tx_byte(tx_byte), .tx_strobe(tx_strobe),
    .cs(cs), .spiclk(spiclk), .mosi(mosi)
  );

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter real PERIOD_NS  = 100.0,
  parameter int  RST_CYCLES = 4
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = !clk;
  end

  initial begin
    arst_n = 1'b0;                    // Asserted from time zero
    repeat (RST_CYCLES) @(posedge clk);
    #10 arst_n = 1'b1;                // Released off the edge
  end

endmodule

//--- tests/walkie_audio_tb.sv
`timescale 1ns/1ps
`include "walkie_audio_config.svh"

module walkie_audio_tb;

  localparam int FRAME_CYCLES    = 2 * `SAMPLE_W * 2 * `I2S_DIV;  // 128 hwclk per frame
  localparam int TOTAL_FRAMES    = 89;                            // Sum over all tests
  localparam int WATCHDOG_CYCLES = TOTAL_FRAMES * FRAME_CYCLES * 3 / 2;

  logic                  hwclk;
  logic                  arst_n;
  logic                  adc_serial_in;
  logic [3:0]            pbs;
  logic [1:0]            vol;
  logic [`WB_DATA_W-1:0] wdati;
  logic                  wack;
  logic                  i2sclk;
  logic                  ws_adc;
  logic                  cs;
  logic                  spiclk;
  logic                  mosi;
  logic [`WB_ADDR_W-1:0] wadr;
  logic [3:0]            wsel;
  logic                  wwe;
  logic                  wstb;
  logic                  wcyc;
  logic [`WB_DATA_W-1:0] wdato;

  walkie_audio_pkg::effect_e model_fx;   // Expected effect selection
  logic                      model_ptt;
  logic                      model_mute;
  logic [1:0]                model_vol;
  logic [7:0]                hist [`DELAY_SAMPLES];  // Last DELAY_SAMPLES mic words
  logic [7:0]                sram [`DELAY_SAMPLES];  // Slave memory, low byte per slot
  logic [7:0]                spi_q [$];              // Expected radio bytes
  logic [40:0]               wb_q [$];               // {we, adr, data} per access
  int                        frame_cnt;
  int                        spi_count;
  int                        wb_count;
  int                        checks;
  int                        errors;
  int                        tests_run;
  int                        tests_failed;
  int                        test_err0;              // Errors before current test
  event                      frame_done;

  tb_clock_gen u_clk (.clk(hwclk), .arst_n(arst_n));

  walkie_audio_top dut (
    .hwclk(hwclk), .arst_n(arst_n), .adc_serial_in(adc_serial_in),
    .pbs(pbs), .vol(vol), .wdati(wdati), .wack(wack),
    .i2sclk(i2sclk), .ws_adc(ws_adc), .cs(cs), .spiclk(spiclk), .mosi(mosi),
    .wadr(wadr), .wsel(wsel), .wwe(wwe), .wstb(wstb), .wcyc(wcyc), .wdato(wdato)
  );

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error at %0d ns: %s expected 0x%0h, got 0x%0h",
               $time, name, expected, actual);
    end
  endtask

  // Reference byte for one frame
  function automatic logic [7:0] effect_model(input walkie_audio_pkg::effect_e fx,
      input logic [7:0] cur, input logic [7:0] old, input logic [1:0] shift);
    logic [8:0] sum;
    logic [7:0] res;
    sum = {1'b0, cur} + {1'b0, old};
    case (fx)
      walkie_audio_pkg::CRUSH:  res = cur & 8'hF0;
      walkie_audio_pkg::ECHO:   res = 8'(sum / 2);
      walkie_audio_pkg::INVERT: res = 8'd255 - cur;
      default:                  res = cur;
    endcase
    return res >> shift;
  endfunction

  task automatic press_button(input int idx);
    @(posedge hwclk);
    #10;
    pbs[idx] = 1'b1;
    repeat (10) @(posedge hwclk);
    #10;
    pbs[idx] = 1'b0;
    repeat (5) @(posedge hwclk);  // Release clears the synchronizer
    case (idx)
      0: model_fx = walkie_audio_pkg::effect_e'(2'(model_fx + 1));  // Wraps to CLEAN
      1: model_mute = !model_mute;
      3: model_fx = walkie_audio_pkg::CLEAN;
      default: ;
    endcase
  endtask

  task automatic set_levels(input logic ptt, input logic [1:0] v);
    @(posedge hwclk);
    #10;
    pbs[2]    = ptt;
    vol       = v;
    model_ptt = ptt;
    model_vol = v;
    repeat (10) @(posedge hwclk);
  endtask

  task automatic run_frames(input int n);
    repeat (n) @(frame_done);
  endtask

  task automatic finish_test(input string name);
    check_value("pending spi bytes", 0, spi_q.size());
    check_value("pending wishbone accesses", 0, wb_q.size());
    tests_run++;
    if (errors != test_err0) begin
      tests_failed++;
    end
    $display("Test %0d %s finished with %0d errors", tests_run, name, errors - test_err0);
    test_err0 = errors;
  endtask

  // Microphone: one random word per frame, MSB first in the ws low half
  initial begin : mic_model
    logic [7:0] cur;
    int         slot;
    adc_serial_in = 1'b0;
    @(posedge arst_n);
    forever begin
      cur  = 8'($urandom);
      slot = frame_cnt % `DELAY_SAMPLES;
      for (int b = 7; b >= 0; b--) begin
        check_value("ws_adc", 0, ws_adc);
        adc_serial_in = cur[b];
        if (b == 0) begin  // Memory pair follows this word
          wb_q.push_back({1'b0, `DELAY_BASE + 32'(4 * slot), 8'h00});
          wb_q.push_back({1'b1, `DELAY_BASE + 32'(4 * slot), cur});
        end
        @(negedge i2sclk);
        #10;
      end
      check_value("ws_adc", 1, ws_adc);
      if (model_ptt && !model_mute) begin
        spi_q.push_back(effect_model(model_fx, cur, hist[slot], model_vol));
      end
      hist[slot] = cur;  // Stored even when not sent
      frame_cnt++;
      repeat (8) begin
        @(negedge i2sclk);
        #10;
      end
      -> frame_done;
    end
  end

  // Wishbone slave with 1 to 3 cycle ack
  initial begin : wb_slave
    int          delay;
    int          slot;
    logic [40:0] want;
    wack  = 1'b0;
    wdati = '0;
    @(posedge arst_n);
    forever begin
      @(posedge hwclk);
      #10;
      if (wcyc && wstb) begin
        wb_count++;
        slot = int'(((wadr - `DELAY_BASE) >> 2) % `DELAY_SAMPLES);
        if (wb_q.size() == 0) begin
          errors++;
          $display("Wishbone access at %0d ns came when none was expected", $time);
        end else begin
          want = wb_q.pop_front();
          check_value("wwe", want[40], wwe);
          check_value("wadr", want[39:8], wadr);
          check_value("wsel", 4'b0001, wsel);
          if (wwe) begin
            check_value("wdato", want[7:0], wdato[7:0]);
          end
        end
        delay = 1 + $urandom % 3;
        repeat (delay - 1) begin
          @(posedge hwclk);
          #10;
        end
        if (wwe) begin
          sram[slot] = wdato[7:0];
        end else begin
          wdati = {24'($urandom), sram[slot]};  // Upper lanes are noise
        end
        wack = 1'b1;
        @(posedge hwclk);
        #10;
        wack = 1'b0;
      end
    end
  end

  // ESP32 side, mosi taken on rising spiclk
  initial begin : spi_capture
    logic [7:0] got;
    int         nbits;
    wait (arst_n === 1'b1);
    forever begin
      @(negedge cs);
      got   = '0;
      nbits = 0;
      while (cs === 1'b0) begin
        @(posedge spiclk or posedge cs);
        if (cs === 1'b0) begin
          got = {got[6:0], mosi};
          nbits++;
        end
      end
      spi_count++;
      check_value("spi bit count", 8, nbits);
      check_value("spiclk at cs release", 0, spiclk);
      if (spi_q.size() == 0) begin
        errors++;
        $display("SPI byte 0x%02h at %0d ns was sent while none was expected", got, $time);
      end else begin
        check_value("mosi byte", spi_q.pop_front(), got);
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge hwclk);
    $display("Run timed out after %0d clock cycles before all tests finished",
             WATCHDOG_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  initial begin : stimulus
    int wb0;
    void'($urandom(21));
    pbs          = '0;
    vol          = '0;
    model_fx     = walkie_audio_pkg::CLEAN;
    model_ptt    = 1'b0;
    model_mute   = 1'b0;
    model_vol    = '0;
    frame_cnt    = 0;
    spi_count    = 0;
    wb_count     = 0;
    checks       = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    test_err0    = 0;
    for (int i = 0; i < `DELAY_SAMPLES; i++) begin
      hist[i] = '0;
      sram[i] = '0;
    end
    @(posedge arst_n);

    set_levels(1'b1, 2'd0);  // PTT held from the first frame
    run_frames(20);
    check_value("spi byte count", 20, spi_count);
    finish_test("clean transmit");

    for (int i = 0; i < 3; i++) begin  // CRUSH, ECHO, INVERT
      press_button(0);
      run_frames(10);
    end
    press_button(3);
    run_frames(2);
    finish_test("effect cycling");

    set_levels(1'b0, 2'd0);  // History fills while silent
    press_button(0);
    press_button(0);
    run_frames(3);
    set_levels(1'b1, 2'd0);
    run_frames(8);
    finish_test("echo history");

    wb0 = wb_count;
    run_frames(8);           // Two ring wraps
    check_value("wishbone access count", 16, wb_count - wb0);
    finish_test("memory traffic");

    set_levels(1'b0, 2'd0);
    run_frames(3);
    set_levels(1'b1, 2'd0);
    press_button(1);         // Mute on
    run_frames(3);
    press_button(1);
    for (int v = 1; v <= 3; v++) begin
      set_levels(1'b1, 2'(v));
      run_frames(4);
    end
    finish_test("gating and volume");

    $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- walkie_audio.f
+incdir+hw
hw/walkie_audio_pkg.sv
hw/audio_bus_if.sv
hw/delay_mem_if.sv
hw/i2s_capture.sv
hw/control_decode.sv
hw/effect_execute.sv
hw/delay_line_wb.sv
hw/esp_spi_result.sv
hw/walkie_audio_top.sv
tests/tb_clock_gen.sv
tests/walkie_audio_tb.sv

//--- Bender.yml
package:
  name: walkie_audio

sources:
  - include_dirs:
      - hw
    files:
      - hw/walkie_audio_pkg.sv
      - hw/audio_bus_if.sv
      - hw/delay_mem_if.sv
      - hw/i2s_capture.sv
      - hw/control_decode.sv
      - hw/effect_execute.sv
      - hw/delay_line_wb.sv
      - hw/esp_spi_result.sv
      - hw/walkie_audio_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/tb_clock_gen.sv
      - tests/walkie_audio_tb.sv
